//--- source/aluPkg.sv
`default_nettype none

package aluPkg;

  localparam int dataWidth  = 32;
  localparam int shamtWidth = 5;

  // control word packing, same as the old ALUControl bus
  localparam int ctrlOpLsb    = 0;
  localparam int ctrlOpMsb    = 5;
  localparam int ctrlShamtLsb = 6;
  localparam int ctrlShamtMsb = 10;

  // status word bits
  localparam int statusCond    = 0;
  localparam int statusIllegal = 1;
  localparam int statusBusy    = 2;

  localparam int intLatency = 1; // single pass through int/shift units
  localparam int mulLatency = 2; // product stage, then accumulate stage

  // kept opcodes only, gaps are the dropped ones
  typedef enum logic [5:0] {
    opAdd   = 6'd0,
    opAddu  = 6'd1,
    opAnd   = 6'd2,
    opSub   = 6'd3,
    opMult  = 6'd4,
    opMultu = 6'd5,
    opMthi  = 6'd6,
    opMtlo  = 6'd7,
    opMfhi  = 6'd8,
    opMflo  = 6'd9,
    opOr    = 6'd11,
    opNor   = 6'd12,
    opXor   = 6'd13,
    opSll   = 6'd14,
    opSlt   = 6'd15,
    opSltu  = 6'd16,
    opSra   = 6'd17,
    opSrav  = 6'd18,
    opSrl   = 6'd19,
    opSrlv  = 6'd20,
    opSllv  = 6'd21,
    opRotrv = 6'd24,
    opRotr  = 6'd25,
    opBeq   = 6'd29,
    opMadd  = 6'd31,
    opMsub  = 6'd32,
    opLui   = 6'd39,
    opBgez  = 6'd40,
    opBltz  = 6'd41,
    opBne   = 6'd42,
    opBgtz  = 6'd43,
    opBlez  = 6'd44,
    opSeh   = 6'd49,
    opSeb   = 6'd50
  } aluOp;

  // APB byte addresses, word aligned
  typedef enum logic [4:0] {
    regOpA    = 5'h00,
    regOpB    = 5'h04,
    regCtrl   = 5'h08,
    regResult = 5'h0C,
    regHi     = 5'h10,
    regLo     = 5'h14,
    regStatus = 5'h18
  } regAddr;

endpackage

`default_nettype wire

//--- source/aluExecIf.sv
`timescale 1ns/1ps
`default_nettype none

interface aluExecIf import aluPkg::*; ();

  // launch side
  logic [dataWidth-1:0]  opA;
  logic [dataWidth-1:0]  opB;
  aluOp                  op;    // valid with start only
  logic [shamtWidth-1:0] shamt; // valid with start only
  logic                  start;

  // result side
  logic                  busy;
  logic [dataWidth-1:0]  result;
  logic [dataWidth-1:0]  hi;
  logic [dataWidth-1:0]  lo;
  logic                  cond;
  logic                  illegal;

  modport regs (
    output opA, opB, op, shamt, start,
    input  busy, result, hi, lo, cond, illegal
  );

  modport core (
    input  opA, opB, op, shamt, start,
    output busy, result, hi, lo, cond, illegal
  );

endinterface

`default_nettype wire

//--- source/intUnit.sv
`timescale 1ns/1ps
`default_nettype none

module intUnit import aluPkg::*;
(
  input  aluOp                 op,
  input  logic [dataWidth-1:0] a,
  input  logic [dataWidth-1:0] b,
  output logic [dataWidth-1:0] result,
  output logic                 cond,
  output logic                 illegal,
  output logic                 hit
);

  logic isBranch;
  logic branchTaken;

  always_comb
  begin
    result      = '0;
    hit         = 1'b1;
    isBranch    = 1'b0;
    branchTaken = 1'b0;
    case (op)
      opAdd, opAddu: result = a + b; // wraps, no overflow trap
      opSub:         result = a - b;
      opAnd:         result = a & b;
      opOr:          result = a | b;
      opNor:         result = ~(a | b);
      opXor:         result = a ^ b;
      opSlt:  result = {{(dataWidth - 1){1'b0}}, $signed(a) < $signed(b)};
      opSltu: result = {{(dataWidth - 1){1'b0}}, a < b};
      opLui:  result = {b[15:0], {(dataWidth - 16){1'b0}}};
      opSeh:  result = {{(dataWidth - 16){b[15]}}, b[15:0]};
      opSeb:  result = {{(dataWidth - 8){b[7]}}, b[7:0]};

      // branches leave result at zero
      opBeq:
      begin
        isBranch    = 1'b1;
        branchTaken = (a == b);
      end
      opBne:
      begin
        isBranch    = 1'b1;
        branchTaken = (a != b);
      end
      opBgez:
      begin
        isBranch    = 1'b1;
        branchTaken = !a[dataWidth-1];
      end
      opBltz:
      begin
        isBranch    = 1'b1;
        branchTaken = a[dataWidth-1];
      end
      opBgtz:
      begin
        isBranch    = 1'b1;
        branchTaken = !a[dataWidth-1] && (a != '0);
      end
      opBlez:
      begin
        isBranch    = 1'b1;
        branchTaken = a[dataWidth-1] || (a == '0);
      end
      default: hit = 1'b0;
    endcase
  end

  assign cond    = isBranch ? branchTaken : (result == '0);
  assign illegal = !hit; // core combines this with the other units

endmodule

`default_nettype wire

//--- source/shiftUnit.sv
`timescale 1ns/1ps
`default_nettype none

module shiftUnit import aluPkg::*;
(
  input  aluOp                  op,
  input  logic [dataWidth-1:0]  b,
  input  logic [shamtWidth-1:0] shamt,
  input  logic [dataWidth-1:0]  a,
  output logic [dataWidth-1:0]  result,
  output logic                  hit
);

  logic                   varAmt;
  logic [shamtWidth-1:0]  amt;
  logic [2*dataWidth-1:0] rotWide;

  // variable forms take the amount from rs
  assign varAmt  = op inside {opSllv, opSrlv, opSrav, opRotrv};
  assign amt     = varAmt ? a[shamtWidth-1:0] : shamt;
  assign rotWide = {b, b} >> amt; // low half is b rotated right

  always_comb
  begin
    hit    = 1'b1;
    result = '0;
    case (op)
      opSll, opSllv:   result = b << amt;
      opSrl, opSrlv:   result = b >> amt;
      opSra, opSrav:   result = $signed(b) >>> amt;
      opRotr, opRotrv: result = rotWide[dataWidth-1:0];
      default:         hit = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

//--- source/hiLoUnit.sv
`timescale 1ns/1ps
`default_nettype none

module hiLoUnit import aluPkg::*;
(
  input  logic                 clk,
  input  logic                 rstN,
  input  aluOp                 op,    // held by the core while busy
  input  logic [dataWidth-1:0] a,
  input  logic [dataWidth-1:0] b,
  input  logic                 start, // first busy cycle
  output logic [dataWidth-1:0] hi,
  output logic [dataWidth-1:0] lo,
  output logic                 hit
);

  logic                   mulOp;
  logic                   stage2;
  logic [2*dataWidth-1:0] product;

  assign mulOp = op inside {opMult, opMultu, opMadd, opMsub};
  assign hit   = mulOp || (op inside {opMthi, opMtlo, opMfhi, opMflo});

  //////////////////////////////////////////////////
  // stage 1, product register
  //////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (start && mulOp)
    begin
      if (op == opMultu)
        product <= a * b;
      else
        product <= $signed(a) * $signed(b); // mult, madd, msub are signed
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rstN)
      stage2 <= 1'b0;
    else
      stage2 <= start && mulOp;
  end

  //////////////////////////////////////////////////
  // stage 2 and the HI/LO pair
  //////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      hi <= '0;
      lo <= '0;
    end
    else if (stage2)
    begin
      case (op)
        opMadd:  {hi, lo} <= {hi, lo} + product;
        opMsub:  {hi, lo} <= {hi, lo} - product;
        default: {hi, lo} <= product; // mult, multu
      endcase
    end
    else if (start && (op == opMthi))
      hi <= a;
    else if (start && (op == opMtlo))
      lo <= a;
  end

endmodule

`default_nettype wire

//--- source/aluCore.sv
`timescale 1ns/1ps
`default_nettype none

module aluCore import aluPkg::*;
(
  input  logic   clk,
  input  logic   rstN,
  aluExecIf.core exec
);

  aluOp                  opReg;
  logic [dataWidth-1:0]  aReg;
  logic [dataWidth-1:0]  bReg;
  logic [shamtWidth-1:0] shamtReg;
  logic                  busy;
  logic                  run;      // first cycle of an operation
  logic [1:0]            cnt;
  logic [1:0]            lastCnt;
  logic                  done;
  logic                  mulGroup;
  logic                  intHit, shiftHit, hiLoHit;
  logic                  intCond, intIllegal;
  logic [dataWidth-1:0]  intResult, shiftResult;
  logic [dataWidth-1:0]  hiVal, loVal;
  logic [dataWidth-1:0]  nextResult;
  logic                  condReg, illegalReg;

  // capture the launched operation, no reset on payload
  always_ff @(posedge clk)
  begin
    if (exec.start)
    begin
      opReg    <= exec.op;
      aReg     <= exec.opA;
      bReg     <= exec.opB;
      shamtReg <= exec.shamt;
    end
  end

  intUnit uInt (.op(opReg), .a(aReg), .b(bReg), .result(intResult), .cond(intCond),
    .illegal(intIllegal), .hit(intHit));

  shiftUnit uShift (.op(opReg), .b(bReg), .shamt(shamtReg), .a(aReg),
    .result(shiftResult), .hit(shiftHit));

  hiLoUnit uHiLo (.clk(clk), .rstN(rstN), .op(opReg), .a(aReg), .b(bReg), .start(run),
    .hi(hiVal), .lo(loVal), .hit(hiLoHit));

  //////////////////////////////////////////////////
  // sequencing
  //////////////////////////////////////////////////

  assign mulGroup = opReg inside {opMult, opMultu, opMadd, opMsub};
  assign lastCnt  = mulGroup ? 2'(mulLatency - 1) : 2'(intLatency - 1);
  assign done     = busy && (cnt == lastCnt);

  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      busy <= 1'b0;
      run  <= 1'b0;
      cnt  <= '0;
    end
    else
    begin
      run <= exec.start;
      if (exec.start)
      begin
        busy <= 1'b1;
        cnt  <= '0;
      end
      else if (done)
        busy <= 1'b0;
      else if (busy)
        cnt <= cnt + 2'd1;
    end
  end

  always_comb
  begin
    if (intHit)
      nextResult = intResult;
    else if (shiftHit)
      nextResult = shiftResult;
    else if (opReg == opMfhi)
      nextResult = hiVal;
    else if (opReg == opMflo)
      nextResult = loVal;
    else
      nextResult = '0; // mult group, mthi/mtlo, unknown opcode
  end

  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      exec.result <= '0;
      condReg     <= 1'b0;
      illegalReg  <= 1'b0;
    end
    else if (done)
    begin
      exec.result <= nextResult;
      condReg     <= intHit ? intCond : (nextResult == '0);
      illegalReg  <= intIllegal && !shiftHit && !hiLoHit;
    end
  end

  assign exec.busy    = busy;
  assign exec.cond    = condReg;
  assign exec.illegal = illegalReg;
  assign exec.hi      = hiVal;
  assign exec.lo      = loVal;

  // longest path is the two-stage multiply
  busyBounded: assert property (@(posedge clk) disable iff (!rstN)
    $rose(busy) |-> ##[1:mulLatency] !busy);

endmodule

`default_nettype wire

//--- source/apbRegs.sv
`timescale 1ns/1ps
`default_nettype none

module apbRegs import aluPkg::*;
(
  input  logic                 clk,
  input  logic                 rstN,
  input  logic [4:0]           paddr,
  input  logic                 psel,
  input  logic                 penable,
  input  logic                 pwrite,
  input  logic [dataWidth-1:0] pwdata,
  output logic [dataWidth-1:0] prdata,
  output logic                 pready,
  output logic                 pslverr,
  aluExecIf.regs               exec
);

  regAddr                addr;
  logic                  access;
  logic                  mapped;
  logic                  readOnly;
  logic                  holdOnBusy;
  logic                  wrDone;
  logic [dataWidth-1:0]  rdData;
  logic [dataWidth-1:0]  statusWord;
  logic [dataWidth-1:0]  opAReg;
  logic [dataWidth-1:0]  opBReg;
  logic [ctrlShamtMsb:0] ctrlReg; // opcode + shamt only

  assign addr   = regAddr'(paddr);
  assign access = psel && penable;

  always_comb
  begin
    statusWord                = '0;
    statusWord[statusCond]    = exec.cond;
    statusWord[statusIllegal] = exec.illegal;
    statusWord[statusBusy]    = exec.busy;
  end

  //////////////////////////////////////////////////
  // address decode and readback
  //////////////////////////////////////////////////

  always_comb
  begin
    mapped     = 1'b1;
    readOnly   = 1'b0;
    holdOnBusy = 1'b0;
    rdData     = '0;
    case (addr)
      regOpA: rdData = opAReg;
      regOpB: rdData = opBReg;
      regCtrl:
      begin
        rdData     = {{(dataWidth - ctrlShamtMsb - 1){1'b0}}, ctrlReg};
        holdOnBusy = pwrite; // no new launch until the core is idle
      end
      regResult:
      begin
        rdData     = exec.result;
        readOnly   = 1'b1;
        holdOnBusy = !pwrite;
      end
      regHi:
      begin
        rdData     = exec.hi;
        readOnly   = 1'b1;
        holdOnBusy = !pwrite;
      end
      regLo:
      begin
        rdData     = exec.lo;
        readOnly   = 1'b1;
        holdOnBusy = !pwrite;
      end
      regStatus:
      begin
        rdData     = statusWord;
        readOnly   = 1'b1;
        holdOnBusy = !pwrite;
      end
      default: mapped = 1'b0;
    endcase
  end

  assign pready  = !(access && holdOnBusy && exec.busy);
  assign pslverr = access && (!mapped || (pwrite && readOnly));
  assign prdata  = rdData;

  // write that finishes this cycle without error
  assign wrDone = access && pwrite && pready && !pslverr;

  //////////////////////////////////////////////////
  // operand and control registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      opAReg  <= '0;
      opBReg  <= '0;
      ctrlReg <= '0;
    end
    else if (wrDone)
    begin
      case (addr)
        regOpA:  opAReg  <= pwdata;
        regOpB:  opBReg  <= pwdata;
        regCtrl: ctrlReg <= pwdata[ctrlShamtMsb:0];
        default: ;
      endcase
    end
  end

  assign exec.opA   = opAReg;
  assign exec.opB   = opBReg;
  assign exec.op    = aluOp'(pwdata[ctrlOpMsb:ctrlOpLsb]); // core samples these with start
  assign exec.shamt = pwdata[ctrlShamtMsb:ctrlShamtLsb];
  assign exec.start = wrDone && (addr == regCtrl);

  // launch only into an idle core, and the core answers with busy
  startWhileIdle: assert property (@(posedge clk) disable iff (!rstN)
    exec.start |-> !exec.busy ##1 exec.busy);

endmodule

`default_nettype wire

//--- source/mipsAlu.sv
`timescale 1ns/1ps
`default_nettype none

module mipsAlu import aluPkg::*;
(
  input  logic                 clk,
  input  logic                 rstN,
  input  logic [4:0]           paddr,
  input  logic                 psel,
  input  logic                 penable,
  input  logic                 pwrite,
  input  logic [dataWidth-1:0] pwdata,
  output logic [dataWidth-1:0] prdata,
  output logic                 pready,
  output logic                 pslverr
);

  aluExecIf exec ();

  // APB side, operands and readback
  apbRegs uRegs (
    .clk     (clk),
    .rstN    (rstN),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .exec    (exec.regs)
  );

  aluCore uCore (
    .clk  (clk),
    .rstN (rstN),
    .exec (exec.core)
  );

endmodule

`default_nettype wire

//--- dv/tbMipsAlu.sv
`timescale 1ns/1ps
`default_nettype none

module tbMipsAlu import aluPkg::*; ();

  localparam int clkPeriod        = 20;
  localparam int resetCycles      = 16;
  localparam int cyclesPerPattern = 50; // 8 transfers, random gaps, mult stalls
  localparam int directedCycles   = 200; // reset reads and error accesses

  typedef struct packed {
    logic [5:0]            op;
    logic [shamtWidth-1:0] shamt;
    logic [dataWidth-1:0]  a;
    logic [dataWidth-1:0]  b;
    logic [dataWidth-1:0]  result;
    logic [dataWidth-1:0]  hi;
    logic [dataWidth-1:0]  lo;
    logic                  cond;
    logic                  illegal;
  } patternT;

  logic                 clk;
  logic                 rstN;
  logic [4:0]           paddr;
  logic                 psel;
  logic                 penable;
  logic                 pwrite;
  logic [dataWidth-1:0] pwdata;
  logic [dataWidth-1:0] prdata;
  logic                 pready;
  logic                 pslverr;

  patternT     patterns[$];
  logic        loaded = 1'b0;
  int unsigned seedInit;

  mipsAlu UUT (
    .clk     (clk),
    .rstN    (rstN),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  initial
  begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////
  // reporting
  //////////////////////////////////////////////////

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic checkValue(input string name, input logic [dataWidth-1:0] got,
    input logic [dataWidth-1:0] exp);
    if (got !== exp)
      abortRun($sformatf("FAIL %s: got 0x%08h, expected 0x%08h", name, got, exp));
  endtask

  //////////////////////////////////////////////////
  // APB master
  //////////////////////////////////////////////////

  task automatic idleBus(input int cycles);
    repeat (cycles)
    begin
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
    end
  endtask

  // returns before the completing edge, outputs sampled mid low phase
  task automatic apbTransfer(input logic [4:0] addr, input logic wr,
    input logic [dataWidth-1:0] wdata, output logic [dataWidth-1:0] rdata,
    output logic err, output int waits);
    waits = 0;
    @(negedge clk);
    paddr   = addr;
    pwrite  = wr;
    pwdata  = wdata;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    #(clkPeriod / 4);
    while (!pready)
    begin
      waits++;
      @(negedge clk);
      #(clkPeriod / 4);
    end
    rdata = prdata;
    err   = pslverr;
  endtask

  task automatic writeReg(input logic [4:0] addr, input logic [dataWidth-1:0] data,
    input logic expErr);
    logic [dataWidth-1:0] rdata;
    logic                 err;
    int                   waits;
    idleBus($urandom % 3);
    apbTransfer(addr, 1'b1, data, rdata, err, waits);
    checkValue($sformatf("pslverr on write to 0x%02h", addr), err, expErr);
  endtask

  task automatic readReg(input logic [4:0] addr, input logic [dataWidth-1:0] exp,
    input logic expErr, input string name);
    logic [dataWidth-1:0] rdata;
    logic                 err;
    int                   waits;
    idleBus($urandom % 3);
    apbTransfer(addr, 1'b0, '0, rdata, err, waits);
    checkValue($sformatf("pslverr on read of 0x%02h", addr), err, expErr);
    if (!expErr)
      checkValue(name, rdata, exp);
  endtask

  //////////////////////////////////////////////////
  // patterns
  //////////////////////////////////////////////////

  function automatic logic [dataWidth-1:0] ctrlWordOf(input patternT p);
    logic [dataWidth-1:0] w;
    w                               = '0;
    w[ctrlOpMsb:ctrlOpLsb]          = p.op;
    w[ctrlShamtMsb:ctrlShamtLsb]    = p.shamt;
    return w;
  endfunction

  function automatic logic [dataWidth-1:0] statusOf(input patternT p);
    logic [dataWidth-1:0] w;
    w                = '0;
    w[statusCond]    = p.cond;
    w[statusIllegal] = p.illegal; // busy always clear once a read completes
    return w;
  endfunction

  task automatic loadPatterns();
    int                   fd;
    int                   count;
    string                line;
    patternT              p;
    logic [dataWidth-1:0] field [0:8];
    fd = $fopen("dv/aluPatterns.txt", "r");
    if (fd == 0)
      abortRun("could not open the pattern file dv/aluPatterns.txt");
    while ($fgets(line, fd) != 0)
    begin
      if (line.len() > 1 && line.getc(0) != "#")
      begin
        count = $sscanf(line, "%h %h %h %h %h %h %h %h %h", field[0], field[1], field[2],
          field[3], field[4], field[5], field[6], field[7], field[8]);
        if (count != 9)
          abortRun($sformatf("malformed line in the pattern file: %s", line));
        p.op      = field[0][5:0];
        p.shamt   = field[1][shamtWidth-1:0];
        p.a       = field[2];
        p.b       = field[3];
        p.result  = field[4];
        p.hi      = field[5];
        p.lo      = field[6];
        p.cond    = field[7][0];
        p.illegal = field[8][0];
        patterns.push_back(p);
      end
    end
    $fclose(fd);
    if (patterns.size() == 0)
      abortRun("the pattern file holds no patterns");
    loaded = 1'b1;
  endtask

  task automatic runPattern(input patternT p, input int idx);
    logic [dataWidth-1:0] rdata;
    logic                 err;
    int                   waits;
    writeReg(regOpA, p.a, 1'b0);
    writeReg(regOpB, p.b, 1'b0);
    writeReg(regCtrl, ctrlWordOf(p), 1'b0);
    if (p.op inside {opMult, opMultu, opMadd, opMsub})
    begin
      // back to back with the launch, HI still in the pipeline
      apbTransfer(regHi, 1'b0, '0, rdata, err, waits);
      checkValue($sformatf("pslverr on held hi read (pattern %0d)", idx), err, 1'b0);
      checkValue($sformatf("hi during mult (pattern %0d)", idx), rdata, p.hi);
      checkValue($sformatf("pready stalled (pattern %0d)", idx), waits != 0, 1'b1);
    end
    readReg(regResult, p.result, 1'b0, $sformatf("result (pattern %0d)", idx));
    readReg(regHi, p.hi, 1'b0, $sformatf("hi (pattern %0d)", idx));
    readReg(regLo, p.lo, 1'b0, $sformatf("lo (pattern %0d)", idx));
    readReg(regStatus, statusOf(p), 1'b0, $sformatf("status (pattern %0d)", idx));
  endtask

  // rejected accesses must leave every register as the last pattern left it
  task automatic errorAccesses();
    patternT last;
    last = patterns[patterns.size() - 1];
    writeReg(regResult, 32'hdeadbeef, 1'b1);
    writeReg(regHi, 32'h0badf00d, 1'b1);
    writeReg(5'h1c, 32'h0000003f, 1'b1);
    writeReg(5'h02, 32'h00000004, 1'b1); // not word aligned
    readReg(5'h1c, '0, 1'b1, "unmapped read");
    readReg(regOpA, last.a, 1'b0, "opA after rejected writes");
    readReg(regOpB, last.b, 1'b0, "opB after rejected writes");
    readReg(regCtrl, ctrlWordOf(last), 1'b0, "ctrl after rejected writes");
    readReg(regResult, last.result, 1'b0, "result after rejected writes");
    readReg(regHi, last.hi, 1'b0, "hi after rejected writes");
    readReg(regLo, last.lo, 1'b0, "lo after rejected writes");
    readReg(regStatus, statusOf(last), 1'b0, "status after rejected writes");
  endtask

  //////////////////////////////////////////////////
  // main sequence and watchdog
  //////////////////////////////////////////////////

  initial
  begin
    rstN     = 1'b0;
    paddr    = '0;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    pwdata   = '0;
    seedInit = $urandom(32'hdf48e1fe);
    loadPatterns();
    repeat (resetCycles) @(negedge clk);
    rstN = 1'b1;

    readReg(regOpA, '0, 1'b0, "opA after reset");
    readReg(regOpB, '0, 1'b0, "opB after reset");
    readReg(regCtrl, '0, 1'b0, "ctrl after reset");
    readReg(regResult, '0, 1'b0, "result after reset");
    readReg(regHi, '0, 1'b0, "hi after reset");
    readReg(regLo, '0, 1'b0, "lo after reset");
    readReg(regStatus, '0, 1'b0, "status after reset");

    foreach (patterns[i])
      runPattern(patterns[i], i);
    errorAccesses();
    idleBus(2);
    $display("TESTS PASSED");
    $finish;
  end

  initial
  begin : watchdog
    int limitCycles;
    wait (loaded);
    limitCycles = resetCycles + patterns.size() * cyclesPerPattern + directedCycles;
    repeat (limitCycles) @(posedge clk);
    abortRun($sformatf("timeout, the run did not finish within %0d cycles", limitCycles));
  end

endmodule

`default_nettype wire

//--- dv/aluPatterns.txt
# columns: op shamt opA opB | expected result hi lo cond illegal, all hex
# hi and lo are the running values after the line has executed
00 00 7fffffff 00000001 80000000 00000000 00000000 0 0
01 00 ffffffff 00000001 00000000 00000000 00000000 1 0
03 00 00000005 00000007 fffffffe 00000000 00000000 0 0
02 00 f0f0ff00 0ff0f0f0 00f0f000 00000000 00000000 0 0
0b 00 12340000 00005678 12345678 00000000 00000000 0 0
0c 00 00000000 ffff0000 0000ffff 00000000 00000000 0 0
0d 00 a5a5a5a5 a5a5a5a5 00000000 00000000 00000000 1 0
0f 00 ffffffff 00000001 00000001 00000000 00000000 0 0
10 00 ffffffff 00000001 00000000 00000000 00000000 1 0
27 00 00000000 0000abcd abcd0000 00000000 00000000 0 0
31 00 00000000 00008001 ffff8001 00000000 00000000 0 0
32 00 00000000 12345680 ffffff80 00000000 00000000 0 0
0e 04 ffffffff 0000000f 000000f0 00000000 00000000 0 0
13 1f 00000000 80000000 00000001 00000000 00000000 0 0
13 04 00000000 0000000f 00000000 00000000 00000000 1 0
11 04 00000000 80000000 f8000000 00000000 00000000 0 0
19 08 00000000 12345678 78123456 00000000 00000000 0 0
15 00 00000024 00000001 00000010 00000000 00000000 0 0
14 03 0000001f ffffffff 00000001 00000000 00000000 0 0
12 00 00000010 80000000 ffff8000 00000000 00000000 0 0
18 00 00000004 0000000f f0000000 00000000 00000000 0 0
1d 00 12345678 12345678 00000000 00000000 00000000 1 0
2a 00 00000000 00000000 00000000 00000000 00000000 0 0
28 00 00000000 00000000 00000000 00000000 00000000 1 0
29 00 80000000 00000000 00000000 00000000 00000000 1 0
2b 00 00000000 00000000 00000000 00000000 00000000 0 0
2c 00 ffffffff 00000000 00000000 00000000 00000000 1 0
06 00 00000001 00000000 00000000 00000001 00000000 1 0
07 00 00000002 00000000 00000000 00000001 00000002 1 0
08 00 00000000 00000000 00000001 00000001 00000002 0 0
04 00 fffffffe 00000003 00000000 ffffffff fffffffa 1 0
1f 00 00000002 00000005 00000000 00000000 00000004 1 0
20 00 00001000 00001000 00000000 ffffffff ff000004 1 0
05 00 ffffffff ffffffff 00000000 fffffffe 00000001 1 0
1f 00 80000000 00000002 00000000 fffffffd 00000001 1 0
09 00 00000000 00000000 00000001 fffffffd 00000001 0 0
08 00 00000000 00000000 fffffffd fffffffd 00000001 0 0
0a 00 11111111 22222222 00000000 fffffffd 00000001 1 1
00 00 00000001 00000001 00000002 fffffffd 00000001 0 0

//--- list.f
source/aluPkg.sv
source/aluExecIf.sv
source/intUnit.sv
source/shiftUnit.sv
source/hiLoUnit.sv
source/aluCore.sv
source/apbRegs.sv
source/mipsAlu.sv
dv/tbMipsAlu.sv
